// File: hdl/ca_cfg_pkg.sv
/*
 * Channel alignment configuration
 * Channel count, word geometry and RX alignment FIFO sizing shared by
 * the receive datapath and its controller
 */

package ca_cfg_pkg;

  ////////////////////////////////////////
  // Channel geometry
  ////////////////////////////////////////
  localparam int NUM_CHANNELS     = 4;   // Parallel die-to-die channels
  localparam int BITS_PER_CHANNEL = 80;  // Word width per channel
  localparam int MARKER_BIT       = 79;  // Alignment marker position in a word

  ////////////////////////////////////////
  // RX alignment FIFO sizing
  ////////////////////////////////////////
  localparam int AD_WIDTH   = 4;             // FIFO address bits
  localparam int FIFO_CNT_W = AD_WIDTH + 1;  // Fill counts and thresholds, 0 to 16

  // Entry count, sized like the fill count so compares stay even
  localparam logic [FIFO_CNT_W-1:0] FIFO_DEPTH = FIFO_CNT_W'(1 << AD_WIDTH);

endpackage

// File: hdl/ca_state_pkg.sv
/*
 * Channel alignment control and status encodings
 * Controller state values and bit positions of the sticky status vector
 */

package ca_state_pkg;

  // Alignment controller states
  typedef enum logic [1:0] {
    CA_IDLE    = 2'd0,  // FIFOs held in soft reset
    CA_HUNT    = 2'd1,  // Discarding words ahead of the marker
    CA_FILL    = 2'd2,  // Building skew margin
    CA_ALIGNED = 2'd3   // Common pops, aligned output
  } ca_align_state_e;

  ////////////////////////////////////////
  // Sticky status vector
  ////////////////////////////////////////
  localparam int STAT_W             = 3;
  localparam int STAT_OVERFLOW_BIT  = 0;  // Word dropped on a full FIFO
  localparam int STAT_FULL_HIT_BIT  = 1;  // Fill reached full threshold
  localparam int STAT_ALIGN_ERR_BIT = 2;  // Markers disagreed on a common pop

endpackage

// File: hdl/ca_sync_fifo.sv
/*
 * Single clock show-ahead FIFO
 * Head word is visible on rddata as soon as it is stored. Keeps a
 * registered fill count and flags pushes that hit a full FIFO.
 */

module ca_sync_fifo
  (
  input  logic                                    com_clk,
  input  logic                                    rst_n,
  input  logic                                    soft_reset,
  input  logic                                    write_push,
  input  logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] wrdata,
  input  logic                                    read_pop,
  output logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] rddata,
  output logic [ca_cfg_pkg::FIFO_CNT_W-1:0]       numfilled,
  output logic                                    full,
  output logic                                    empty,
  output logic                                    overflow_pulse
  );

  // Storage, no reset on the payload
  logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] mem [ca_cfg_pkg::FIFO_DEPTH];

  logic [ca_cfg_pkg::AD_WIDTH:0] wr_ptr;  // Extra MSB tells full from empty
  logic [ca_cfg_pkg::AD_WIDTH:0] rd_ptr;
  logic                          do_write;
  logic                          do_read;

  ////////////////////////////////////////
  // Flags
  ////////////////////////////////////////
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ca_cfg_pkg::AD_WIDTH] != rd_ptr[ca_cfg_pkg::AD_WIDTH]) &&
                 (wr_ptr[ca_cfg_pkg::AD_WIDTH-1:0] == rd_ptr[ca_cfg_pkg::AD_WIDTH-1:0]);

  assign do_write       = write_push & ~full & ~soft_reset;  // Soft reset wins over push
  assign do_read        = read_pop & ~empty;                 // Pop on empty ignored
  assign overflow_pulse = write_push & full;                 // Word lost this cycle

  // Show-ahead head word
  assign rddata = mem[rd_ptr[ca_cfg_pkg::AD_WIDTH-1:0]];

  always_ff @(posedge com_clk)
  begin
    if (do_write)
    begin
      mem[wr_ptr[ca_cfg_pkg::AD_WIDTH-1:0]] <= wrdata;
    end
  end

  ////////////////////////////////////////
  // Pointers and fill count
  ////////////////////////////////////////
  always_ff @(posedge com_clk)
  begin
    if (!rst_n || soft_reset)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      numfilled <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   numfilled <= numfilled + 1'b1;  // Push only
        2'b01:   numfilled <= numfilled - 1'b1;  // Pop only
        default: numfilled <= numfilled;         // Both or neither
      endcase
    end
  end

endmodule

// File: hdl/ca_rx_align_fifo.sv
/*
 * RX channel alignment FIFO
 * One per channel. Buffers incoming words on com_clk, derives the
 * programmable level flags from the fill count and presents the
 * marker bit of the head word.
 */

module ca_rx_align_fifo
  (
  input  logic                                    com_clk,
  input  logic                                    rst_n,
  input  logic                                    soft_reset,
  input  logic                                    fifo_push,
  input  logic                                    fifo_pop,
  input  logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] rx_din,
  output logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] rx_dout,
  output logic                                    rd_empty,
  output logic                                    head_marker,
  output logic                                    wr_overflow_pulse,
  input  logic [ca_cfg_pkg::FIFO_CNT_W-1:0]       fifo_full_val,
  input  logic [ca_cfg_pkg::FIFO_CNT_W-1:0]       fifo_pempty_val,
  output logic                                    fifo_full,
  output logic                                    fifo_pempty
  );

  logic [ca_cfg_pkg::FIFO_CNT_W-1:0] rd_numfilled;  // Entries held
  logic                              wr_full;

  ////////////////////////////////////////
  // Alignment buffer
  ////////////////////////////////////////
  ca_sync_fifo sync_fifo_i
    (
    .com_clk        (com_clk),
    .rst_n          (rst_n),
    .soft_reset     (soft_reset),
    .write_push     (fifo_push),
    .wrdata         (rx_din),
    .read_pop       (fifo_pop),
    .rddata         (rx_dout),
    .numfilled      (rd_numfilled),
    .full           (wr_full),
    .empty          (rd_empty),
    .overflow_pulse (wr_overflow_pulse)
    );

  // Level flags, combinational from the count
  always_comb
  begin
    // A threshold beyond the depth still flags once the FIFO is full
    fifo_full   = wr_full | (rd_numfilled >= fifo_full_val);
    fifo_pempty = (rd_numfilled <= fifo_pempty_val);
  end

  // Marker of a real head only, empty reads as no marker
  assign head_marker = ~rd_empty & rx_dout[ca_cfg_pkg::MARKER_BIT];

endmodule

// File: hdl/ca_align_ctrl.sv
/*
 * Channel alignment controller
 * Discards pre-marker words per channel, waits for fill margin, then
 * pops all channels together and watches the popped markers agree.
 */

module ca_align_ctrl
  (
  input  logic com_clk,
  input  logic rst_n,
  input  logic align_en,
  input  logic rd_empty    [ca_cfg_pkg::NUM_CHANNELS],
  input  logic head_marker [ca_cfg_pkg::NUM_CHANNELS],
  input  logic fifo_pempty [ca_cfg_pkg::NUM_CHANNELS],
  output logic fifo_pop    [ca_cfg_pkg::NUM_CHANNELS],
  output logic soft_reset,
  output logic rx_dout_valid,
  output logic rx_align_done,
  output logic align_start,
  output logic marker_err
  );

  ca_state_pkg::ca_align_state_e state_q;
  ca_state_pkg::ca_align_state_e state_d;

  logic align_en_q;   // For the rising edge
  logic all_ready;    // No channel empty
  logic all_marker;   // Every head is a marker
  logic any_marker;
  logic any_pempty;   // Some channel still short of margin

  ////////////////////////////////////////
  // Cross-channel reductions
  ////////////////////////////////////////
  always_comb
  begin
    all_ready  = 1'b1;
    all_marker = 1'b1;
    any_marker = 1'b0;
    any_pempty = 1'b0;
    for (int i = 0; i < ca_cfg_pkg::NUM_CHANNELS; i++)
    begin
      all_ready  = all_ready & ~rd_empty[i];
      all_marker = all_marker & head_marker[i];  // Implies non-empty
      any_marker = any_marker | head_marker[i];
      any_pempty = any_pempty | fifo_pempty[i];
    end
  end

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    state_d       = state_q;
    soft_reset    = 1'b0;
    rx_dout_valid = 1'b0;
    align_start   = 1'b0;
    marker_err    = 1'b0;
    for (int i = 0; i < ca_cfg_pkg::NUM_CHANNELS; i++)
      fifo_pop[i] = 1'b0;

    case (state_q)
      ca_state_pkg::CA_IDLE:
      begin
        soft_reset = 1'b1;  // Keep every FIFO empty
        if (align_en && !align_en_q)
        begin
          state_d     = ca_state_pkg::CA_HUNT;
          align_start = 1'b1;  // Clears sticky status
        end
      end
      ca_state_pkg::CA_HUNT:
      begin
        // Drop heads that are present but not markers
        for (int i = 0; i < ca_cfg_pkg::NUM_CHANNELS; i++)
          fifo_pop[i] = ~rd_empty[i] & ~head_marker[i];
        if (all_marker)
          state_d = ca_state_pkg::CA_FILL;
      end
      ca_state_pkg::CA_FILL:
      begin
        if (!any_pempty)
          state_d = ca_state_pkg::CA_ALIGNED;  // Skew margin reached
      end
      ca_state_pkg::CA_ALIGNED:
      begin
        if (all_ready)
        begin
          rx_dout_valid = 1'b1;  // Common pop
          for (int i = 0; i < ca_cfg_pkg::NUM_CHANNELS; i++)
            fifo_pop[i] = 1'b1;
          if (any_marker && !all_marker)
          begin
            marker_err = 1'b1;
            state_d    = ca_state_pkg::CA_HUNT;  // Realign on next common marker
          end
        end
      end
      default: state_d = ca_state_pkg::CA_IDLE;
    endcase

    if (!align_en)
      state_d = ca_state_pkg::CA_IDLE;  // Disable overrides any state
  end

  always_ff @(posedge com_clk)
  begin
    if (!rst_n)
    begin
      state_q    <= ca_state_pkg::CA_IDLE;
      align_en_q <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      align_en_q <= align_en;
    end
  end

  assign rx_align_done = (state_q == ca_state_pkg::CA_ALIGNED);

endmodule

// File: hdl/ca_align_status.sv
/*
 * Channel alignment status
 * Folds per-channel FIFO events and controller marker errors into
 * sticky bits, cleared at the start of each alignment.
 */

module ca_align_status
  (
  input  logic com_clk,
  input  logic rst_n,
  input  logic align_start,
  input  logic wr_overflow_pulse [ca_cfg_pkg::NUM_CHANNELS],
  input  logic fifo_full         [ca_cfg_pkg::NUM_CHANNELS],
  input  logic marker_err,
  output logic stat_overflow,
  output logic stat_full_hit,
  output logic stat_align_err
  );

  logic [ca_state_pkg::STAT_W-1:0] stat_q;    // Sticky bits
  logic [ca_state_pkg::STAT_W-1:0] stat_set;  // Events this cycle

  always_comb
  begin
    stat_set = '0;
    stat_set[ca_state_pkg::STAT_ALIGN_ERR_BIT] = marker_err;
    for (int i = 0; i < ca_cfg_pkg::NUM_CHANNELS; i++)
    begin
      stat_set[ca_state_pkg::STAT_OVERFLOW_BIT] =
        stat_set[ca_state_pkg::STAT_OVERFLOW_BIT] | wr_overflow_pulse[i];
      stat_set[ca_state_pkg::STAT_FULL_HIT_BIT] =
        stat_set[ca_state_pkg::STAT_FULL_HIT_BIT] | fifo_full[i];
    end
  end

  always_ff @(posedge com_clk)
  begin
    if (!rst_n || align_start)
      stat_q <= '0;               // New alignment starts clean
    else
      stat_q <= stat_q | stat_set;
  end

  assign stat_overflow  = stat_q[ca_state_pkg::STAT_OVERFLOW_BIT];
  assign stat_full_hit  = stat_q[ca_state_pkg::STAT_FULL_HIT_BIT];
  assign stat_align_err = stat_q[ca_state_pkg::STAT_ALIGN_ERR_BIT];

endmodule

// File: hdl/ca_rx_top.sv
/*
 * RX channel alignment top
 * One alignment FIFO per channel, a common controller that aligns
 * the channel heads, and the sticky status block
 */

module ca_rx_top
  (
  input  logic                                    com_clk,
  input  logic                                    rst_n,
  input  logic                                    align_en,
  input  logic                                    rx_push [ca_cfg_pkg::NUM_CHANNELS],
  input  logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] rx_din  [ca_cfg_pkg::NUM_CHANNELS],
  input  logic [ca_cfg_pkg::FIFO_CNT_W-1:0]       fifo_full_val,
  input  logic [ca_cfg_pkg::FIFO_CNT_W-1:0]       fifo_pempty_val,
  output logic [ca_cfg_pkg::BITS_PER_CHANNEL-1:0] rx_dout [ca_cfg_pkg::NUM_CHANNELS],
  output logic                                    rx_dout_valid,
  output logic                                    rx_align_done,
  output logic                                    stat_overflow,
  output logic                                    stat_full_hit,
  output logic                                    stat_align_err
  );

  // Per-channel handshake with the controller and status block
  logic fifo_pop          [ca_cfg_pkg::NUM_CHANNELS];
  logic rd_empty          [ca_cfg_pkg::NUM_CHANNELS];
  logic head_marker       [ca_cfg_pkg::NUM_CHANNELS];
  logic fifo_pempty       [ca_cfg_pkg::NUM_CHANNELS];
  logic fifo_full         [ca_cfg_pkg::NUM_CHANNELS];
  logic wr_overflow_pulse [ca_cfg_pkg::NUM_CHANNELS];

  logic soft_reset;   // Shared by all FIFOs
  logic align_start;
  logic marker_err;

  ////////////////////////////////////////
  // Channel FIFOs
  ////////////////////////////////////////
  for (genvar ch = 0; ch < ca_cfg_pkg::NUM_CHANNELS; ch++)
  begin : g_ch
    ca_rx_align_fifo rx_align_fifo_i
      (
      .com_clk           (com_clk),
      .rst_n             (rst_n),
      .soft_reset        (soft_reset),
      .fifo_push         (rx_push[ch]),
      .fifo_pop          (fifo_pop[ch]),
      .rx_din            (rx_din[ch]),
      .rx_dout           (rx_dout[ch]),
      .rd_empty          (rd_empty[ch]),
      .head_marker       (head_marker[ch]),
      .wr_overflow_pulse (wr_overflow_pulse[ch]),
      .fifo_full_val     (fifo_full_val),
      .fifo_pempty_val   (fifo_pempty_val),
      .fifo_full         (fifo_full[ch]),
      .fifo_pempty       (fifo_pempty[ch])
      );
  end

  ca_align_ctrl align_ctrl_i
    (
    .com_clk       (com_clk),
    .rst_n         (rst_n),
    .align_en      (align_en),
    .rd_empty      (rd_empty),
    .head_marker   (head_marker),
    .fifo_pempty   (fifo_pempty),
    .fifo_pop      (fifo_pop),
    .soft_reset    (soft_reset),
    .rx_dout_valid (rx_dout_valid),
    .rx_align_done (rx_align_done),
    .align_start   (align_start),
    .marker_err    (marker_err)
    );

  ca_align_status align_status_i
    (
    .com_clk           (com_clk),
    .rst_n             (rst_n),
    .align_start       (align_start),
    .wr_overflow_pulse (wr_overflow_pulse),
    .fifo_full         (fifo_full),
    .marker_err        (marker_err),
    .stat_overflow     (stat_overflow),
    .stat_full_hit     (stat_full_hit),
    .stat_align_err    (stat_align_err)
    );

endmodule

// File: testbench/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * 20 ns com_clk, rst_n held low for the first 4 cycles
 */

module tb_clk_gen
  (
  output logic com_clk,
  output logic rst_n
  );

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    com_clk = 1'b0;
    forever #10 com_clk = ~com_clk;  // 20 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge com_clk);
    #2 rst_n = 1'b1;  // Release off the edge, like other inputs
  end

endmodule

// File: testbench/ca_rx_top_chk.sv
/*
 * Protocol checker for the RX channel alignment top
 * Bound into the DUT, watches output valid, done and soft reset
 */

module ca_rx_top_chk
  (
  input logic com_clk,
  input logic rst_n,
  input logic align_en,
  input logic soft_reset,
  input logic marker_err,
  input logic rx_dout_valid,
  input logic rx_align_done
  );

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Rule violations seen so far

  ////////////////////////////////////////
  // Output rules
  ////////////////////////////////////////
  a_valid_needs_done: assert property (@(posedge com_clk) disable iff (!rst_n)
    rx_dout_valid |-> rx_align_done)
    else
    begin
      $error("rx_dout_valid seen outside the aligned state");
      fail_cnt++;
    end

  // Done drops only on disable or a marker error
  a_done_holds: assert property (@(posedge com_clk) disable iff (!rst_n)
    (rx_align_done && align_en && !marker_err) |=> rx_align_done)
    else
    begin
      $error("rx_align_done fell without disable or marker error");
      fail_cnt++;
    end

  a_no_valid_in_reset: assert property (@(posedge com_clk) disable iff (!rst_n)
    soft_reset |-> !rx_dout_valid)
    else
    begin
      $error("rx_dout_valid while FIFOs held in soft reset");
      fail_cnt++;
    end

endmodule

bind ca_rx_top ca_rx_top_chk ca_rx_top_chk_i
  (
  .com_clk       (com_clk),
  .rst_n         (rst_n),
  .align_en      (align_en),
  .soft_reset    (soft_reset),     // Internal controller net
  .marker_err    (marker_err),
  .rx_dout_valid (rx_dout_valid),
  .rx_align_done (rx_align_done)
  );

// File: testbench/tb_ca_rx_top.sv
/*
 * Testbench for the RX channel alignment top
 * Streams skewed, gapped words with periodic markers into every channel
 * and checks aligned output, margin, sticky status and recovery
 */

module tb_ca_rx_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NCH        = ca_cfg_pkg::NUM_CHANNELS;
  localparam int WW         = ca_cfg_pkg::BITS_PER_CHANNEL;
  localparam int MARK_EVERY = 8;     // Marker period of a good stream
  localparam int TMO_CYC    = 2000;  // Cycle limit of every wait

  // Wait conditions
  localparam int W_RESET   = 0;
  localparam int W_DONE    = 1;
  localparam int W_NOTDONE = 2;
  localparam int W_ALGERR  = 3;
  localparam int W_OUTCNT  = 4;

  logic                              com_clk;
  logic                              rst_n;
  logic                              align_en;
  logic                              rx_push [NCH];
  logic [WW-1:0]                     rx_din  [NCH];
  logic [ca_cfg_pkg::FIFO_CNT_W-1:0] fifo_full_val;
  logic [ca_cfg_pkg::FIFO_CNT_W-1:0] fifo_pempty_val;
  logic [WW-1:0]                     rx_dout [NCH];
  logic                              rx_dout_valid;
  logic                              rx_align_done;
  logic                              stat_overflow;
  logic                              stat_full_hit;
  logic                              stat_align_err;

  int next_idx [NCH];  // Stream words driven per channel
  bit pend     [NCH];  // Driven this cycle, not yet clocked in
  int out_idx;         // Next expected output index
  int start_idx;       // Marker index the current alignment began at
  int target_out;
  int inj_ch;          // Channel carrying a stray marker
  int inj_idx;         // -1 for a clean stream
  int errors;

  tb_clk_gen clk_gen_i (.com_clk(com_clk), .rst_n(rst_n));

  ca_rx_top ca_rx_top_inst
    (
    .com_clk         (com_clk),
    .rst_n           (rst_n),
    .align_en        (align_en),
    .rx_push         (rx_push),
    .rx_din          (rx_din),
    .fifo_full_val   (fifo_full_val),
    .fifo_pempty_val (fifo_pempty_val),
    .rx_dout         (rx_dout),
    .rx_dout_valid   (rx_dout_valid),
    .rx_align_done   (rx_align_done),
    .stat_overflow   (stat_overflow),
    .stat_full_hit   (stat_full_hit),
    .stat_align_err  (stat_align_err)
    );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Index low, channel above it, marker every MARK_EVERY words
  function automatic logic [WW-1:0] expected_word(input int ch, input int idx);
    logic [WW-1:0] w;
    w                         = '0;
    w[15:0]                   = idx[15:0];
    w[23:16]                  = ch[7:0];
    w[ca_cfg_pkg::MARKER_BIT] = (idx % MARK_EVERY == 0);
    return w;
  endfunction

  function automatic logic [WW-1:0] junk_word();
    return WW'(32'hee00_0000) | WW'($urandom_range(16'hffff, 0));  // Never a marker
  endfunction

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    a_bit: assert (got === exp)
      else abort_run($sformatf("ERROR t=%0t %s got %0b exp %0b", $time, name, got, exp));
  endtask

  function automatic bit cond_met(input int sel);
    case (sel)
      W_RESET:   return rst_n;
      W_DONE:    return rx_align_done;
      W_NOTDONE: return !rx_align_done;
      W_ALGERR:  return stat_align_err;
      default:   return out_idx >= target_out;
    endcase
  endfunction

  task automatic wait_cond(input int sel, input string what);
    int cyc;
    cyc = 0;
    while (!cond_met(sel))
    begin
      @(negedge com_clk);  // Mid-cycle, outputs settled
      cyc++;
      if (cyc > TMO_CYC)
        abort_run($sformatf("Timeout while waiting for %s", what));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  // Skewed, gapped stream of indices first..last-1 on every channel
  task automatic run_stream(input int first, input int last);
    int junk_left [NCH];
    int min_idx;
    int cyc;
    for (int ch = 0; ch < NCH; ch++)
    begin
      junk_left[ch] = (first == 0) ? $urandom_range(5, 0) : 0;  // Channel skew
      next_idx[ch]  = first;
    end
    cyc = 0;
    do
    begin
      @(posedge com_clk);
      #2;
      min_idx = last;
      for (int ch = 0; ch < NCH; ch++)
        if (next_idx[ch] < min_idx)
          min_idx = next_idx[ch];
      for (int ch = 0; ch < NCH; ch++)
      begin
        rx_push[ch] = 1'b0;
        pend[ch]    = 1'b0;
        if ($urandom_range(3, 0) != 0)  // Gap about one cycle in four
        begin
          if (junk_left[ch] > 0)
          begin
            rx_din[ch]  = junk_word();
            rx_push[ch] = 1'b1;
            junk_left[ch]--;
          end
          // Lead over the slowest channel capped, FIFOs never overflow
          else if (next_idx[ch] < last && next_idx[ch] - min_idx < MARK_EVERY)
          begin
            rx_din[ch] = expected_word(ch, next_idx[ch]);
            if (ch == inj_ch && next_idx[ch] == inj_idx)
              rx_din[ch][ca_cfg_pkg::MARKER_BIT] = 1'b1;  // Off-period marker
            rx_push[ch] = 1'b1;
            pend[ch]    = 1'b1;
            next_idx[ch]++;
          end
        end
      end
      cyc++;
      if (cyc > TMO_CYC)
        abort_run("Timeout while pushing the channel streams");
    end
    while (min_idx < last);
  endtask

  // Channels 0 to NCH-2 get words first..last back to back, last channel junk
  task automatic push_burst(input int first, input int last);
    for (int k = first; k <= last; k++)
    begin
      @(posedge com_clk);
      #2;
      for (int ch = 0; ch < NCH; ch++)
      begin
        rx_push[ch] = 1'b1;
        rx_din[ch]  = (ch == NCH - 1) ? junk_word() : expected_word(ch, k);
      end
    end
    @(posedge com_clk);
    #2;
    for (int ch = 0; ch < NCH; ch++)
      rx_push[ch] = 1'b0;
    @(posedge com_clk);  // Sticky bits settle here
    @(negedge com_clk);
  endtask

  task automatic enable_align();
    @(posedge com_clk);
    #2 align_en = 1'b1;
    @(posedge com_clk);
    @(negedge com_clk);
  endtask

  task automatic disable_align();
    @(posedge com_clk);
    #2 align_en = 1'b0;
    wait_cond(W_NOTDONE, "rx_align_done to fall");
    repeat (2) @(posedge com_clk);
    @(negedge com_clk);
  endtask

  ////////////////////////////////////////
  // Output comparison
  ////////////////////////////////////////
  always @(negedge com_clk)
  begin
    logic [WW-1:0] exp_w;
    int            landed;
    if (rst_n && rx_dout_valid)
    begin
      for (int ch = 0; ch < NCH; ch++)
      begin
        exp_w = expected_word(ch, out_idx);
        if (ch == inj_ch && out_idx == inj_idx)
          exp_w[ca_cfg_pkg::MARKER_BIT] = 1'b1;
        landed = next_idx[ch] - int'(pend[ch]);
        a_data: assert (rx_dout[ch] === exp_w)
          else abort_run($sformatf("ERROR t=%0t rx_dout[%0d] got %h exp %h",
                                   $time, ch, rx_dout[ch], exp_w));
        // Margin reached before the first common pop
        a_margin: assert (landed - start_idx > int'(fifo_pempty_val))
          else abort_run($sformatf("ERROR t=%0t words_landed[%0d] got %0d exp > %0d",
                                   $time, ch, landed - start_idx, fifo_pempty_val));
      end
      if (out_idx == inj_idx)
      begin
        out_idx   = (out_idx / MARK_EVERY + 1) * MARK_EVERY;  // Next common marker
        start_idx = out_idx;
      end
      else
        out_idx++;
    end
  end

  // Bound protocol checker
  always @(negedge com_clk)
  begin
    a_proto: assert (ca_rx_top_inst.ca_rx_top_chk_i.fail_cnt == 0)
      else abort_run("Protocol checker found a broken output rule");
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    void'($urandom(32'hf3b9));  // One seed for the whole run
    align_en        = 1'b0;
    fifo_full_val   = 5'd14;
    fifo_pempty_val = 5'd3;
    for (int ch = 0; ch < NCH; ch++)
    begin
      rx_push[ch]  = 1'b0;
      rx_din[ch]   = '0;
      next_idx[ch] = 0;
      pend[ch]     = 1'b0;
    end
    out_idx    = 0;
    start_idx  = 0;
    target_out = 0;
    inj_ch     = -1;
    inj_idx    = -1;
    errors     = 0;
    wait_cond(W_RESET, "reset release");

    // Disabled: pushes dropped, outputs quiet
    repeat (20)  // More pushes than FIFO entries
    begin
      @(posedge com_clk);
      #2;
      for (int ch = 0; ch < NCH; ch++)
      begin
        rx_push[ch] = 1'b1;
        rx_din[ch]  = junk_word();
      end
      @(negedge com_clk);
      check_bit("rx_dout_valid", rx_dout_valid, 1'b0);
      check_bit("rx_align_done", rx_align_done, 1'b0);
      check_bit("stat_overflow", stat_overflow, 1'b0);
      check_bit("stat_full_hit", stat_full_hit, 1'b0);
      check_bit("stat_align_err", stat_align_err, 1'b0);
    end
    @(posedge com_clk);
    #2;
    for (int ch = 0; ch < NCH; ch++)
      rx_push[ch] = 1'b0;

    // Skewed streams align
    enable_align();
    run_stream(0, 40);
    wait_cond(W_DONE, "rx_align_done");
    target_out = 40;
    wait_cond(W_OUTCNT, "40 aligned outputs");
    check_bit("stat_overflow", stat_overflow, 1'b0);
    check_bit("stat_align_err", stat_align_err, 1'b0);

    // Stray marker on channel 1, realign at index 48
    inj_ch  = 1;
    inj_idx = 45;
    fork
      run_stream(40, 96);
      begin
        wait_cond(W_ALGERR, "stat_align_err");
        check_bit("rx_align_done", rx_align_done, 1'b0);
      end
    join
    wait_cond(W_DONE, "rx_align_done after realignment");
    target_out = 96;
    wait_cond(W_OUTCNT, "outputs after realignment");

    // Disable, then a fresh alignment with cleared status
    disable_align();
    check_bit("stat_align_err", stat_align_err, 1'b1);  // Sticky while disabled
    inj_ch    = -1;
    inj_idx   = -1;
    out_idx   = 0;
    start_idx = 0;
    enable_align();
    check_bit("stat_align_err", stat_align_err, 1'b0);
    run_stream(0, 32);
    wait_cond(W_DONE, "rx_align_done on fresh stream");
    target_out = 32;
    wait_cond(W_OUTCNT, "outputs of fresh stream");

    // Last channel never marks, others fill up and overflow
    disable_align();
    @(posedge com_clk);
    #2 fifo_full_val = 5'd10;
    enable_align();
    push_burst(0, 8);
    check_bit("stat_full_hit", stat_full_hit, 1'b0);  // Fill 9
    push_burst(9, 15);
    check_bit("stat_full_hit", stat_full_hit, 1'b1);  // Fill 16
    check_bit("stat_overflow", stat_overflow, 1'b0);
    push_burst(16, 16);
    check_bit("stat_overflow", stat_overflow, 1'b1);  // 17th word dropped
    check_bit("rx_align_done", rx_align_done, 1'b0);

    if (errors == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("*** FAILED ***");
      $fatal(1, "Errors found");
    end
  end

endmodule

// File: src.f
hdl/ca_cfg_pkg.sv
hdl/ca_state_pkg.sv
hdl/ca_sync_fifo.sv
hdl/ca_rx_align_fifo.sv
hdl/ca_align_ctrl.sv
hdl/ca_align_status.sv
hdl/ca_rx_top.sv
testbench/tb_clk_gen.sv
testbench/ca_rx_top_chk.sv
testbench/tb_ca_rx_top.sv

// File: Bender.yml
package:
  name: ca_rx_align

sources:
  # Packages first, then the datapath bottom up
  - target: any(rtl, test)
    files:
      - hdl/ca_cfg_pkg.sv
      - hdl/ca_state_pkg.sv
      - hdl/ca_sync_fifo.sv
      - hdl/ca_rx_align_fifo.sv
      - hdl/ca_align_ctrl.sv
      - hdl/ca_align_status.sv
      - hdl/ca_rx_top.sv

  # Testbench, clock source and bound checker
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/ca_rx_top_chk.sv
      - testbench/tb_ca_rx_top.sv
